//--- design/ex_pkg.sv
// execute stage shared types: opcodes, funct fields, instruction formats, control and result
package ex_pkg;

    localparam int XLEN_W = 64;
    localparam int PC_W   = 32;
    localparam int INST_W = 32;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;

    // integer op group
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    // branch group
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // sub, sra

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NEVER, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_B, MEM_H, MEM_W, MEM_D} mem_size_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      sel_a_pc;  // auipc
        logic      sel_b_imm;
        logic      is_word;
        logic [4:0] rd;
        logic      rd_we;
        br_cond_e  br_cond;
        logic      is_jalr;
        logic      is_load;
        logic      is_store;
        mem_size_e mem_size;
        logic      load_signed;
    } ex_ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [4:0]        rd;
        logic              rd_we;
        logic [XLEN_W-1:0] wb_data;
        logic              is_jmp;
        logic [PC_W-1:0]   jmp_target;
        logic              is_load;
        logic              is_store;
        logic [XLEN_W-1:0] mem_addr;
        mem_size_e         mem_size;
        logic              load_signed;
        logic [XLEN_W-1:0] store_data;
    } ex_result_t;

endpackage

//--- design/inst_decoder.sv
// instruction decoder: raw word to control struct and sign-extended immediate
`timescale 1ns/1ps

module inst_decoder import ex_pkg::*; (
    input  inst_u             i_inst,
    output ex_ctrl_t          o_ctrl,
    output logic [XLEN_W-1:0] o_imm
);

    logic [XLEN_W-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic              r_alt, sh_alt;
    logic              rd_we;

    assign imm_i = {{52{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
    assign imm_s = {{52{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
    assign imm_b = {{51{i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                    i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
    assign imm_u = {{32{i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'h000};
    assign imm_j = {{43{i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                    i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

    assign r_alt  = (i_inst.r.funct7 == FUNCT7_ALT);
    assign sh_alt = (i_inst.r.funct7[6:1] == FUNCT7_ALT[6:1]); // funct7[0] is shamt[5]

    // sub only exists in the register forms
    function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic alt,
                                        input logic has_sub);
        case (f3)
            F3_ADD_SUB: alu_dec = (alt && has_sub) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_dec = ALU_SLL;
            F3_SLT:     alu_dec = ALU_SLT;
            F3_SLTU:    alu_dec = ALU_SLTU;
            F3_XOR:     alu_dec = ALU_XOR;
            F3_SRL_SRA: alu_dec = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_dec = ALU_OR;
            default:    alu_dec = ALU_AND;
        endcase
    endfunction

    function automatic br_cond_e br_dec(input logic [2:0] f3);
        case (f3)
            F3_BEQ:  br_dec = BR_EQ;
            F3_BNE:  br_dec = BR_NE;
            F3_BLT:  br_dec = BR_LT;
            F3_BGE:  br_dec = BR_GE;
            F3_BLTU: br_dec = BR_LTU;
            F3_BGEU: br_dec = BR_GEU;
            default: br_dec = BR_NEVER; // reserved encodings never branch
        endcase
    endfunction

    always_comb begin
        o_ctrl = '0; // unknown opcode stays a no-op
        o_imm  = '0;
        rd_we  = 1'b0;
        case (i_inst.r.opcode)
            OPC_OP, OPC_OP_32: begin
                o_ctrl.alu_op  = alu_dec(i_inst.r.funct3, r_alt, 1'b1);
                o_ctrl.is_word = (i_inst.r.opcode == OPC_OP_32);
                rd_we          = 1'b1;
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                o_imm            = imm_i;
                o_ctrl.sel_b_imm = 1'b1;
                o_ctrl.alu_op    = alu_dec(i_inst.i.funct3, sh_alt, 1'b0);
                o_ctrl.is_word   = (i_inst.i.opcode == OPC_OP_IMM_32);
                rd_we            = 1'b1;
            end
            OPC_LUI: begin
                o_imm            = imm_u;
                o_ctrl.sel_b_imm = 1'b1;
                o_ctrl.alu_op    = ALU_PASS_B;
                rd_we            = 1'b1;
            end
            OPC_AUIPC: begin
                o_imm            = imm_u;
                o_ctrl.sel_a_pc  = 1'b1;
                o_ctrl.sel_b_imm = 1'b1;
                rd_we            = 1'b1;
            end
            OPC_JAL: begin
                o_imm          = imm_j;
                o_ctrl.br_cond = BR_ALWAYS;
                rd_we          = 1'b1;
            end
            OPC_JALR: begin
                o_imm          = imm_i;
                o_ctrl.br_cond = BR_ALWAYS;
                o_ctrl.is_jalr = 1'b1;
                rd_we          = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm          = imm_b;
                o_ctrl.br_cond = br_dec(i_inst.b.funct3);
            end
            OPC_LOAD: begin
                o_imm              = imm_i;
                o_ctrl.is_load     = 1'b1;
                o_ctrl.mem_size    = mem_size_e'(i_inst.i.funct3[1:0]);
                o_ctrl.load_signed = ~i_inst.i.funct3[2];
                rd_we              = 1'b1;
            end
            OPC_STORE: begin
                o_imm           = imm_s;
                o_ctrl.is_store = 1'b1;
                o_ctrl.mem_size = mem_size_e'(i_inst.s.funct3[1:0]);
            end
            default: ;
        endcase
        o_ctrl.rd_we = rd_we && (i_inst.r.rd != 5'd0); // x0 is never written
        o_ctrl.rd    = o_ctrl.rd_we ? i_inst.r.rd : 5'd0;
    end

endmodule

//--- design/int_alu.sv
// integer ALU with word-form sign extension and link value for jumps
`timescale 1ns/1ps

module int_alu import ex_pkg::*; (
    input  ex_ctrl_t          i_ctrl,
    input  logic [PC_W-1:0]   i_pc,
    input  logic [XLEN_W-1:0] i_rs1_value,
    input  logic [XLEN_W-1:0] i_rs2_value,
    input  logic [XLEN_W-1:0] i_imm,
    output logic [XLEN_W-1:0] o_wb_data
);

    logic [XLEN_W-1:0] op_a, op_b;
    logic [XLEN_W-1:0] srl_src, sra_src;
    logic [XLEN_W-1:0] res;
    logic [5:0]        shamt;
    logic [PC_W-1:0]   link;

    assign op_a = i_ctrl.sel_a_pc ? {{(XLEN_W-PC_W){1'b0}}, i_pc} : i_rs1_value;
    assign op_b = i_ctrl.sel_b_imm ? i_imm : i_rs2_value;

    // word shifts use 5 bits and see only the low word of A
    assign shamt   = i_ctrl.is_word ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign srl_src = i_ctrl.is_word ? {32'h0, op_a[31:0]} : op_a;
    assign sra_src = i_ctrl.is_word ? {{32{op_a[31]}}, op_a[31:0]} : op_a;

    assign link = i_pc + 32'd4;

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:    res = op_a + op_b;
            ALU_SUB:    res = op_a - op_b;
            ALU_SLL:    res = op_a << shamt;
            ALU_SLT:    res = {{(XLEN_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   res = {{(XLEN_W-1){1'b0}}, op_a < op_b};
            ALU_XOR:    res = op_a ^ op_b;
            ALU_SRL:    res = srl_src >> shamt;
            ALU_SRA:    res = $signed(sra_src) >>> shamt;
            ALU_OR:     res = op_a | op_b;
            ALU_AND:    res = op_a & op_b;
            ALU_PASS_B: res = op_b; // lui
            default:    res = '0;
        endcase
    end

    always_comb begin
        if (i_ctrl.br_cond == BR_ALWAYS) begin
            o_wb_data = {{(XLEN_W-PC_W){1'b0}}, link}; // jal, jalr
        end else if (i_ctrl.is_word) begin
            o_wb_data = {{32{res[31]}}, res[31:0]};
        end else begin
            o_wb_data = res;
        end
    end

endmodule

//--- design/branch_unit.sv
// branch condition evaluation and jump target
`timescale 1ns/1ps

module branch_unit import ex_pkg::*; (
    input  ex_ctrl_t          i_ctrl,
    input  logic [PC_W-1:0]   i_pc,
    input  logic [XLEN_W-1:0] i_rs1_value,
    input  logic [XLEN_W-1:0] i_rs2_value,
    input  logic [XLEN_W-1:0] i_imm,
    output logic              o_taken,
    output logic [PC_W-1:0]   o_target
);

    logic              eq, lt, ltu;
    logic [XLEN_W-1:0] jalr_sum;
    logic [PC_W-1:0]   target;

    assign eq  = (i_rs1_value == i_rs2_value);
    assign lt  = $signed(i_rs1_value) < $signed(i_rs2_value);
    assign ltu = i_rs1_value < i_rs2_value;

    always_comb begin
        case (i_ctrl.br_cond)
            BR_ALWAYS: o_taken = 1'b1;
            BR_EQ:     o_taken = eq;
            BR_NE:     o_taken = ~eq;
            BR_LT:     o_taken = lt;
            BR_GE:     o_taken = ~lt;
            BR_LTU:    o_taken = ltu;
            BR_GEU:    o_taken = ~ltu;
            default:   o_taken = 1'b0;
        endcase
    end

    assign jalr_sum = i_rs1_value + i_imm;
    assign target   = i_ctrl.is_jalr ? {jalr_sum[PC_W-1:1], 1'b0}
                                     : i_pc + i_imm[PC_W-1:0];

    assign o_target = o_taken ? target : '0;

endmodule

//--- design/agu.sv
// address generation and store data alignment for loads and stores
`timescale 1ns/1ps

module agu import ex_pkg::*; (
    input  ex_ctrl_t          i_ctrl,
    input  logic [XLEN_W-1:0] i_rs1_value,
    input  logic [XLEN_W-1:0] i_rs2_value,
    input  logic [XLEN_W-1:0] i_imm,
    output logic [XLEN_W-1:0] o_mem_addr,
    output logic [XLEN_W-1:0] o_store_data
);

    logic is_mem;

    assign is_mem     = i_ctrl.is_load | i_ctrl.is_store;
    assign o_mem_addr = is_mem ? i_rs1_value + i_imm : '0;

    // low bytes only, upper bits zero
    always_comb begin
        o_store_data = '0;
        if (i_ctrl.is_store) begin
            case (i_ctrl.mem_size)
                MEM_B:   o_store_data = {56'h0, i_rs2_value[7:0]};
                MEM_H:   o_store_data = {48'h0, i_rs2_value[15:0]};
                MEM_W:   o_store_data = {32'h0, i_rs2_value[31:0]};
                default: o_store_data = i_rs2_value;
            endcase
        end
    end

endmodule

//--- design/ex_result_reg.sv
// output pipeline register of the execute stage, strobes gated by valid and flush
`timescale 1ns/1ps

module ex_result_reg import ex_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_valid,
    input  logic              i_flush,
    input  ex_ctrl_t          i_ctrl,
    input  logic [XLEN_W-1:0] i_wb_data,
    input  logic              i_taken,
    input  logic [PC_W-1:0]   i_target,
    input  logic [XLEN_W-1:0] i_mem_addr,
    input  logic [XLEN_W-1:0] i_store_data,
    output ex_result_t        o_result
);

    logic       valid_in;
    ex_result_t result_q;

    assign valid_in = i_valid & ~i_flush;

    always_ff @(posedge clk) begin
        // payload follows the input every cycle
        result_q.rd          <= i_ctrl.rd;
        result_q.wb_data     <= i_wb_data;
        result_q.jmp_target  <= i_target;
        result_q.mem_addr    <= i_mem_addr;
        result_q.mem_size    <= i_ctrl.mem_size;
        result_q.load_signed <= i_ctrl.load_signed;
        result_q.store_data  <= i_store_data;

        if (reset) begin
            result_q.valid    <= 1'b0;
            result_q.rd_we    <= 1'b0;
            result_q.is_jmp   <= 1'b0;
            result_q.is_load  <= 1'b0;
            result_q.is_store <= 1'b0;
        end else begin
            result_q.valid    <= valid_in;
            result_q.rd_we    <= valid_in & i_ctrl.rd_we;
            result_q.is_jmp   <= valid_in & i_taken;
            result_q.is_load  <= valid_in & i_ctrl.is_load;
            result_q.is_store <= valid_in & i_ctrl.is_store;
        end
    end

    assign o_result = result_q;

endmodule

//--- design/ex_stage_top.sv
// execute stage top: decoder and functional units in parallel, one result register
`timescale 1ns/1ps

module ex_stage_top import ex_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_valid,
    input  logic [PC_W-1:0]   i_pc,
    input  logic [INST_W-1:0] i_inst,
    input  logic [XLEN_W-1:0] i_rs1_value,
    input  logic [XLEN_W-1:0] i_rs2_value,
    input  logic              i_flush,
    output ex_result_t        o_result
);

    ex_ctrl_t          ctrl;
    logic [XLEN_W-1:0] imm;
    logic [XLEN_W-1:0] wb_data;
    logic              taken;
    logic [PC_W-1:0]   target;
    logic [XLEN_W-1:0] mem_addr;
    logic [XLEN_W-1:0] store_data;

    inst_decoder u_inst_decoder (
        .i_inst (i_inst),
        .o_ctrl (ctrl),
        .o_imm  (imm)
    );

    int_alu u_int_alu (
        .i_ctrl      (ctrl),
        .i_pc        (i_pc),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .i_imm       (imm),
        .o_wb_data   (wb_data)
    );

    branch_unit u_branch_unit (
        .i_ctrl      (ctrl),
        .i_pc        (i_pc),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .i_imm       (imm),
        .o_taken     (taken),
        .o_target    (target)
    );

    agu u_agu (
        .i_ctrl       (ctrl),
        .i_rs1_value  (i_rs1_value),
        .i_rs2_value  (i_rs2_value),
        .i_imm        (imm),
        .o_mem_addr   (mem_addr),
        .o_store_data (store_data)
    );

    ex_result_reg u_ex_result_reg (
        .clk          (clk),
        .reset        (reset),
        .i_valid      (i_valid),
        .i_flush      (i_flush),
        .i_ctrl       (ctrl),
        .i_wb_data    (wb_data),
        .i_taken      (taken),
        .i_target     (target),
        .i_mem_addr   (mem_addr),
        .i_store_data (store_data),
        .o_result     (o_result)
    );

endmodule

//--- test/ex_stage_properties.sv
// result register properties: strobe exclusivity, jump target alignment, no write to x0
`timescale 1ns/1ps

module ex_stage_properties import ex_pkg::*; (
    input logic       clk,
    input logic       reset,
    input ex_result_t i_result
);

    // a result is a load or a store, never both
    load_store_excl: assert property (@(posedge clk) disable iff (reset)
        !(i_result.is_load && i_result.is_store))
        else $error("load and store strobes are both set");

    jmp_target_even: assert property (@(posedge clk) disable iff (reset)
        i_result.is_jmp |-> !i_result.jmp_target[0])
        else $error("jump target has bit 0 set");

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        i_result.rd_we |-> (i_result.rd != 5'd0))
        else $error("register write enabled with rd equal to zero");

endmodule

bind ex_result_reg ex_stage_properties u_ex_stage_properties (
    .clk      (clk),
    .reset    (reset),
    .i_result (o_result)
);

//--- test/ex_checker.sv
// execute stage checker with a reference model of each instruction and a field compare
`timescale 1ns/1ps

module ex_checker import ex_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_valid,
    input  logic              i_flush,
    input  logic [PC_W-1:0]   i_pc,
    input  logic [INST_W-1:0] i_inst,
    input  logic [XLEN_W-1:0] i_rs1_value,
    input  logic [XLEN_W-1:0] i_rs2_value,
    input  ex_result_t        i_result,
    output int                o_errors,
    output int                o_checks
);

    logic              have_prev;
    logic              prev_reset;
    logic              prev_valid;
    logic [PC_W-1:0]   prev_pc;
    logic [INST_W-1:0] prev_inst;
    logic [XLEN_W-1:0] prev_a, prev_b;
    ex_result_t        exp_r;

    function automatic logic [63:0] alu_value(input logic [2:0] f3, input logic alt,
                                              input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: return (a < b) ? 64'd1 : 64'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[5:0];
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // 32-bit result with bit 31 copied into the upper word
    function automatic logic [63:0] word_alu_value(input logic [2:0] f3, input logic alt,
                                                   input logic [63:0] a, input logic [63:0] b);
        logic [31:0] x;
        case (f3)
            3'd0: x = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'd1: x = a[31:0] << b[4:0];
            3'd5: begin
                if (alt) x = $signed(a[31:0]) >>> b[4:0];
                else x = a[31:0] >> b[4:0];
            end
            default: x = 32'h0;
        endcase
        return {{32{x[31]}}, x};
    endfunction

    function automatic ex_result_t ref_result(input logic valid, input logic [31:0] pc,
                                              input logic [31:0] inst,
                                              input logic [63:0] a, input logic [63:0] b);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
        logic        wr, taken;
        logic [63:0] sum;
        ex_result_t  r;
        f3    = inst[14:12];
        rd    = inst[11:7];
        imm_i = {{52{inst[31]}}, inst[31:20]};
        imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
        imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        r     = '0;
        wr    = 1'b0;
        taken = 1'b0;
        case (inst[6:0])
            OPC_OP: begin
                wr = 1'b1;
                r.wb_data = alu_value(f3, inst[30], a, b);
            end
            OPC_OP_IMM:    begin
                wr = 1'b1;
                r.wb_data = alu_value(f3, (f3 == 3'd5) && inst[30], a, imm_i);
            end
            OPC_OP_32: begin
                wr = 1'b1;
                r.wb_data = word_alu_value(f3, inst[30], a, b);
            end
            OPC_OP_IMM_32: begin
                wr = 1'b1;
                r.wb_data = word_alu_value(f3, (f3 == 3'd5) && inst[30], a, imm_i);
            end
            OPC_LUI: begin
                wr = 1'b1;
                r.wb_data = imm_u;
            end
            OPC_AUIPC: begin
                wr = 1'b1;
                r.wb_data = {32'h0, pc} + imm_u;
            end
            OPC_JAL, OPC_JALR: begin
                wr = 1'b1;
                taken = 1'b1;
                r.wb_data = {32'h0, pc + 32'd4}; // link
                sum = a + imm_i;
                if (inst[6:0] == OPC_JAL) r.jmp_target = pc + imm_j[31:0];
                else r.jmp_target = {sum[31:1], 1'b0};
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = $signed(a) < $signed(b);
                    F3_BGE:  taken = $signed(a) >= $signed(b);
                    F3_BLTU: taken = a < b;
                    F3_BGEU: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                r.jmp_target = taken ? pc + imm_b[31:0] : 32'h0;
            end
            OPC_LOAD: begin
                wr = 1'b1;
                r.is_load     = valid;
                r.mem_addr    = a + imm_i;
                r.mem_size    = mem_size_e'(f3[1:0]);
                r.load_signed = ~f3[2]; // lbu, lhu, lwu are zero-extended
            end
            OPC_STORE: begin
                r.is_store = valid;
                r.mem_addr = a + imm_s;
                r.mem_size = mem_size_e'(f3[1:0]);
                case (f3[1:0])
                    2'd0:    r.store_data = {56'h0, b[7:0]};
                    2'd1:    r.store_data = {48'h0, b[15:0]};
                    2'd2:    r.store_data = {32'h0, b[31:0]};
                    default: r.store_data = b;
                endcase
            end
            default: ; // unknown opcode has no effect
        endcase
        r.valid  = valid;
        r.rd     = (wr && rd != 5'd0) ? rd : 5'd0;
        r.rd_we  = valid && wr && (rd != 5'd0);
        r.is_jmp = valid && taken;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        o_checks++;
        if (act_v !== exp_v) begin
            o_errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic compare_result(input ex_result_t e, input ex_result_t a);
        check_field("valid", 64'(e.valid), 64'(a.valid));
        check_field("rd_we", 64'(e.rd_we), 64'(a.rd_we));
        check_field("is_jmp", 64'(e.is_jmp), 64'(a.is_jmp));
        check_field("is_load", 64'(e.is_load), 64'(a.is_load));
        check_field("is_store", 64'(e.is_store), 64'(a.is_store));
        if (e.valid) begin
            check_field("rd", 64'(e.rd), 64'(a.rd));
            check_field("jmp_target", 64'(e.jmp_target), 64'(a.jmp_target));
            check_field("mem_addr", e.mem_addr, a.mem_addr);
            check_field("store_data", e.store_data, a.store_data);
            if (e.rd_we && !e.is_load) check_field("wb_data", e.wb_data, a.wb_data);
            if (e.is_load || e.is_store) begin
                check_field("mem_size", 64'(e.mem_size), 64'(a.mem_size));
                check_field("load_signed", 64'(e.load_signed), 64'(a.load_signed));
            end
        end
    endtask

    initial begin
        have_prev = 1'b0;
        o_errors  = 0;
        o_checks  = 0;
    end

    // result is stable at the falling edge and the inputs are already those of the next edge
    always @(negedge clk) begin
        if (have_prev) begin
            if (prev_reset) exp_r = '0;
            else exp_r = ref_result(prev_valid, prev_pc, prev_inst, prev_a, prev_b);
            compare_result(exp_r, i_result);
        end
        have_prev  = 1'b1;
        prev_reset = reset;
        prev_valid = i_valid && !i_flush;
        prev_pc    = i_pc;
        prev_inst  = i_inst;
        prev_a     = i_rs1_value;
        prev_b     = i_rs2_value;
    end

endmodule

//--- test/tb_ex_stage.sv
// execute stage testbench with clock, reset, random instruction stimulus and timeout
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

    localparam logic [31:0] SEED = 32'h6db09f53;
    localparam int RESET_CYCLES = 2;
    localparam int N_KINDS      = 8; // alu, word, upper, branch, jump, load, store, unknown
    localparam int N_PER_KIND   = 60;
    localparam int N_MIXED      = 150;
    localparam int DRAIN_CYCLES = 3;
    localparam int STIM_CYCLES  = RESET_CYCLES + N_KINDS * N_PER_KIND + N_MIXED + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 20;

    logic              clk;
    logic              reset;
    logic              i_valid;
    logic              i_flush;
    logic [PC_W-1:0]   i_pc;
    logic [INST_W-1:0] i_inst;
    logic [XLEN_W-1:0] i_rs1_value;
    logic [XLEN_W-1:0] i_rs2_value;
    ex_result_t        o_result;
    int                errors;
    int                checks;
    int                cycle_count;

    ex_stage_top u_ex_stage_top (
        .clk         (clk),
        .reset       (reset),
        .i_valid     (i_valid),
        .i_pc        (i_pc),
        .i_inst      (i_inst),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .i_flush     (i_flush),
        .o_result    (o_result)
    );

    ex_checker u_ex_checker (
        .clk         (clk),
        .reset       (reset),
        .i_valid     (i_valid),
        .i_flush     (i_flush),
        .i_pc        (i_pc),
        .i_inst      (i_inst),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .i_result    (o_result),
        .o_errors    (errors),
        .o_checks    (checks)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // mix of full random, small signed and sign-boundary values
    function automatic logic [63:0] rand_operand();
        logic [31:0] r;
        r = $urandom;
        case ($urandom % 5)
            0: return {$urandom, r};
            1: return {{56{r[7]}}, r[7:0]};
            2: return {32'h0, 32'h7fff_fff0 + (r % 32)}; // word overflow
            3: return {32'h8000_0000, r[7:0], 24'h0};
            default: return {32'hffff_ffff, r};
        endcase
    endfunction

    function automatic logic [31:0] make_inst(input int kind);
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        logic        alt;
        int          sel;
        f3   = 3'($urandom);
        rd   = 5'($urandom);
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        imm  = 12'($urandom);
        boff = 13'($urandom);
        joff = 21'($urandom);
        alt  = 1'($urandom);
        sel  = int'($urandom % 3);
        case (kind)
            0: begin
                if ($urandom % 2 == 0) begin
                    alt = alt && (f3 == 3'd0 || f3 == 3'd5);
                    return {alt ? FUNCT7_ALT : 7'h00, rs2, rs1, f3, rd, OPC_OP};
                end
                if (f3 == 3'd1) imm[11:6] = 6'h00;
                if (f3 == 3'd5) imm[11:6] = alt ? 6'b010000 : 6'h00;
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            1: begin
                f3  = (sel == 0) ? 3'd0 : (sel == 1) ? 3'd1 : 3'd5;
                alt = alt && (f3 != 3'd1);
                if ($urandom % 2 == 0) begin
                    return {alt ? FUNCT7_ALT : 7'h00, rs2, rs1, f3, rd, OPC_OP_32};
                end
                if (f3 != 3'd0) imm[11:5] = alt ? FUNCT7_ALT : 7'h00;
                return {imm, rs1, f3, rd, OPC_OP_IMM_32};
            end
            2: return {20'($urandom), rd, alt ? OPC_LUI : OPC_AUIPC};
            3: begin
                f3 = 3'($urandom % 6);
                if (f3 > 3'd1) f3 = f3 + 3'd2; // skip the two reserved codes
                return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
            end
            4: begin
                if (alt) return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
                return {imm, rs1, 3'b000, rd, OPC_JALR};
            end
            5: return {imm, rs1, 3'($urandom % 7), rd, OPC_LOAD};
            6: return {imm[11:5], rs2, rs1, 1'b0, 2'($urandom), imm[4:0], OPC_STORE};
            default: begin
                // fence, system and a reserved opcode
                return {25'($urandom), (sel == 0) ? 7'b0001111 :
                                       (sel == 1) ? 7'b1110011 : 7'b1111111};
            end
        endcase
    endfunction

    task automatic send_inst(input logic valid, input logic flush, input int kind);
        logic [63:0] a, b;
        logic [31:0] inst;
        a    = rand_operand();
        b    = rand_operand();
        inst = make_inst(kind);
        if (kind == 3 && $urandom % 3 == 0) b = a; // equal operands for beq, bge
        @(posedge clk);
        i_valid     <= valid;
        i_flush     <= flush;
        i_pc        <= $urandom & 32'hffff_fffc;
        i_inst      <= inst;
        i_rs1_value <= a;
        i_rs2_value <= b;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        cycle_count = 0;
        reset       = 1'b1;
        i_valid     = 1'b0;
        i_flush     = 1'b0;
        i_pc        = '0;
        i_inst      = '0;
        i_rs1_value = '0;
        i_rs2_value = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // back to back with one kind at a time
        for (int k = 0; k < N_KINDS; k++) begin
            for (int n = 0; n < N_PER_KIND; n++) send_inst(1'b1, 1'b0, k);
        end
        // gaps and flushes over all kinds
        for (int n = 0; n < N_MIXED; n++) begin
            send_inst($urandom % 4 != 0, $urandom % 6 == 0, int'($urandom % N_KINDS));
        end
        repeat (DRAIN_CYCLES) send_inst(1'b0, 1'b0, 0);
        @(posedge clk);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
design/ex_pkg.sv
design/inst_decoder.sv
design/int_alu.sv
design/branch_unit.sv
design/agu.sv
design/ex_result_reg.sv
design/ex_stage_top.sv
test/ex_stage_properties.sv
test/ex_checker.sv
test/tb_ex_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_stage -Mdir obj_dir -f list.f

out=$(./obj_dir/Vtb_ex_stage 2>&1) || true
echo "$out"

if grep -qx "Simulation passed" <<< "$out"; then
    exit 0
else
    exit 1
fi
